// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module alu_cluster_tb -f src.f -o alu_cluster_sim \
    && ./obj_dir/alu_cluster_sim > sim.log 2>&1 || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "^Result: PASSED$" sim.log 2>/dev/null && exit 0 || exit 1

// ==== source/alu.sv ====
module alu #(
    parameter int PREG_BITS = 6,
    parameter int ID_BITS   = 4
) (
    input  logic                 ex_valid,
    input  alu_pkg::alu_op_t     ex_op,
    input  logic [ID_BITS-1:0]   ex_id,
    input  alu_pkg::word_t       ex_pc,
    input  alu_pkg::word_t       ex_imm,
    input  logic                 ex_src1_is_imm,
    input  logic [PREG_BITS-1:0] ex_dst_reg,
    input  logic                 ex_dst_we,
    input  alu_pkg::word_t       ex_pred_target,
    input  alu_pkg::cp0_addr_t   ex_cp0_addr,
    input  alu_pkg::word_t       rdata0,
    input  alu_pkg::word_t       rdata1,
    output alu_pkg::cp0_addr_t   cp0_addr,
    output alu_pkg::word_t       cp0_wdata,
    output logic                 cp0_we,
    input  alu_pkg::word_t       cp0_rdata,
    output logic                 res_valid,
    output logic [ID_BITS-1:0]   res_id,
    output alu_pkg::word_t       res_data,
    output logic [PREG_BITS-1:0] res_reg,
    output logic                 res_we,
    output logic                 res_exc,
    output alu_pkg::exc_code_t   res_exc_code,
    output logic                 res_br,
    output logic                 res_taken,
    output alu_pkg::word_t       res_target,
    output alu_pkg::word_t       res_pc
);
    import alu_pkg::*;

    word_t       src0;
    word_t       src1;
    word_t       logic_res;
    word_t       shift_res;
    word_t       add_b;
    word_t       sum;
    word_t       cnt_src;
    logic [5:0]  lead_cnt;
    logic signed [31:0] sra_res;
    logic        sub_op;
    logic        overflow;
    logic        lt_s;
    logic        is_br;
    logic        taken;
    logic        adel;

    assign src0 = rdata0;
    assign src1 = ex_src1_is_imm ? ex_imm : rdata1;

    always_comb begin
        case (ex_op)
            OP_OR:   logic_res = src0 | src1;
            OP_AND:  logic_res = src0 & src1;
            OP_NOR:  logic_res = ~(src0 | src1);
            OP_XOR:  logic_res = src0 ^ src1;
            OP_LUI:  logic_res = {src1[15:0], 16'h0000};
            default: logic_res = '0;
        endcase
    end

    assign sra_res = $signed(src0) >>> src1[4:0];

    always_comb begin
        case (ex_op)
            OP_SLL:  shift_res = src0 << src1[4:0];
            OP_SRL:  shift_res = src0 >> src1[4:0];
            OP_SRA:  shift_res = sra_res;
            default: shift_res = '0;
        endcase
    end

    // one adder for add and sub
    assign sub_op   = (ex_op == OP_SUB) || (ex_op == OP_SUBU);
    assign add_b    = sub_op ? ~src1 : src1;
    assign sum      = src0 + add_b + {31'b0, sub_op};
    assign overflow = ((ex_op == OP_ADD) || (ex_op == OP_SUB))
                    && (src0[31] == add_b[31]) && (sum[31] != src0[31]);

    assign lt_s = $signed(src0) < $signed(src1);

    // leading ones counted as leading zeros of the inverse
    assign cnt_src = (ex_op == OP_CLO) ? ~src0 : src0;

    always_comb begin
        lead_cnt = 6'd32;
        for (int i = 0; i < 32; i++) begin
            if (cnt_src[i]) lead_cnt = 6'(31 - i);  // highest set bit wins
        end
    end

    always_comb begin
        is_br = 1'b1;
        case (ex_op)
            OP_BEQ:  taken = (src0 == src1);
            OP_BNE:  taken = (src0 != src1);
            OP_BGEZ: taken = ~src0[31];
            OP_BLTZ: taken = src0[31];
            OP_JR,
            OP_JAL:  taken = 1'b1;
            default: begin
                is_br = 1'b0;
                taken = 1'b0;
            end
        endcase
    end

    assign res_target = (ex_op == OP_JR) ? src0 : ex_pred_target;
    assign adel       = is_br && taken && (|res_target[1:0]);  // misaligned fetch

    always_comb begin
        case (ex_op)
            OP_OR, OP_AND, OP_NOR, OP_XOR, OP_LUI: res_data = logic_res;
            OP_SLL, OP_SRL, OP_SRA:                res_data = shift_res;
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU:      res_data = sum;
            OP_SLT:                                res_data = {31'b0, lt_s};
            OP_SLTU:                               res_data = {31'b0, src0 < src1};
            OP_CLZ, OP_CLO:                        res_data = {26'b0, lead_cnt};
            OP_BEQ, OP_BNE, OP_BGEZ, OP_BLTZ,
            OP_JR, OP_JAL:                         res_data = ex_pc + 32'd8;  // link
            OP_MFC0:                               res_data = cp0_rdata;
            default:                               res_data = '0;
        endcase
    end

    assign cp0_addr  = ex_cp0_addr;
    assign cp0_wdata = src0;
    assign cp0_we    = ex_valid && (ex_op == OP_MTC0);

    assign res_valid    = ex_valid;
    assign res_id       = ex_id;
    assign res_reg      = ex_dst_reg;
    assign res_we       = ex_valid && ex_dst_we;
    assign res_exc      = ex_valid && (adel || overflow);
    assign res_exc_code = adel ? EXC_ADEL_IF : (overflow ? EXC_OV : EXC_NONE);
    assign res_br       = ex_valid && is_br;
    assign res_taken    = ex_valid && taken;
    assign res_pc       = ex_pc;

endmodule

// ==== source/alu_cluster.sv ====
module alu_cluster #(
    parameter int PREG_BITS = 6,
    parameter int ID_BITS   = 4
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 issue_req,
    output logic                 issue_ack,
    input  alu_pkg::alu_op_t     op,
    input  logic [ID_BITS-1:0]   id,
    input  alu_pkg::word_t       pc,
    input  alu_pkg::word_t       imm,
    input  logic [PREG_BITS-1:0] src0_reg,
    input  logic [PREG_BITS-1:0] src1_reg,
    input  logic                 src1_is_imm,
    input  logic [PREG_BITS-1:0] dst_reg,
    input  logic                 dst_we,
    input  alu_pkg::word_t       pred_target,
    input  alu_pkg::cp0_addr_t   cp0_addr,
    output logic                 done,
    output logic [ID_BITS-1:0]   done_id,
    output logic                 exc,
    output alu_pkg::exc_code_t   exc_code,
    output logic                 br_taken,
    output alu_pkg::word_t       br_target,
    output logic                 wb_we,
    output logic [PREG_BITS-1:0] wb_reg,
    output alu_pkg::word_t       wb_data
);
    import alu_pkg::*;

    logic [PREG_BITS-1:0] raddr0, raddr1, ex_dst_reg, res_reg;
    word_t                rdata0, rdata1, ex_pc, ex_imm, ex_pred_target;
    logic                 ex_valid, ex_src1_is_imm, ex_dst_we;
    alu_op_t              ex_op;
    logic [ID_BITS-1:0]   ex_id, res_id;
    cp0_addr_t            ex_cp0_addr, cp0_raddr;
    word_t                cp0_wdata, cp0_rdata, exc_pc;
    logic                 cp0_we;
    logic                 res_valid, res_we, res_exc, res_br, res_taken;
    word_t                res_data, res_target, res_pc;
    exc_code_t            res_exc_code;

    prf #(.PREG_BITS(PREG_BITS)) prf0 (
        .clk(clk), .arst_n(arst_n), .raddr0(raddr0), .raddr1(raddr1),
        .rdata0(rdata0), .rdata1(rdata1), .we(wb_we), .waddr(wb_reg), .wdata(wb_data)
    );

    issue_stage #(.PREG_BITS(PREG_BITS), .ID_BITS(ID_BITS)) issue0 (
        .clk(clk), .arst_n(arst_n), .issue_req(issue_req), .issue_ack(issue_ack),
        .op(op), .id(id), .pc(pc), .imm(imm), .src0_reg(src0_reg), .src1_reg(src1_reg),
        .src1_is_imm(src1_is_imm), .dst_reg(dst_reg), .dst_we(dst_we),
        .pred_target(pred_target), .cp0_addr(cp0_addr), .raddr0(raddr0), .raddr1(raddr1),
        .ex_valid(ex_valid), .ex_op(ex_op), .ex_id(ex_id), .ex_pc(ex_pc), .ex_imm(ex_imm),
        .ex_src1_is_imm(ex_src1_is_imm), .ex_dst_reg(ex_dst_reg), .ex_dst_we(ex_dst_we),
        .ex_pred_target(ex_pred_target), .ex_cp0_addr(ex_cp0_addr)
    );

    alu #(.PREG_BITS(PREG_BITS), .ID_BITS(ID_BITS)) alu0 (
        .ex_valid(ex_valid), .ex_op(ex_op), .ex_id(ex_id), .ex_pc(ex_pc), .ex_imm(ex_imm),
        .ex_src1_is_imm(ex_src1_is_imm), .ex_dst_reg(ex_dst_reg), .ex_dst_we(ex_dst_we),
        .ex_pred_target(ex_pred_target), .ex_cp0_addr(ex_cp0_addr),
        .rdata0(rdata0), .rdata1(rdata1),
        .cp0_addr(cp0_raddr), .cp0_wdata(cp0_wdata), .cp0_we(cp0_we), .cp0_rdata(cp0_rdata),
        .res_valid(res_valid), .res_id(res_id), .res_data(res_data), .res_reg(res_reg),
        .res_we(res_we), .res_exc(res_exc), .res_exc_code(res_exc_code), .res_br(res_br),
        .res_taken(res_taken), .res_target(res_target), .res_pc(res_pc)
    );

    // exception capture uses the registered completion report
    cp0_regs cp0_0 (
        .clk(clk), .arst_n(arst_n), .addr(cp0_raddr), .wdata(cp0_wdata), .we(cp0_we),
        .rdata(cp0_rdata), .exc_en(exc), .exc_pc(exc_pc), .exc_badvaddr(br_target),
        .exc_code(exc_code)
    );

    wb_stage #(.PREG_BITS(PREG_BITS), .ID_BITS(ID_BITS)) wb0 (
        .clk(clk), .arst_n(arst_n), .res_valid(res_valid), .res_id(res_id),
        .res_data(res_data), .res_reg(res_reg), .res_we(res_we), .res_exc(res_exc),
        .res_exc_code(res_exc_code), .res_br(res_br), .res_taken(res_taken),
        .res_target(res_target), .res_pc(res_pc), .done(done), .done_id(done_id),
        .exc(exc), .exc_code(exc_code), .br_taken(br_taken), .br_target(br_target),
        .wb_we(wb_we), .wb_reg(wb_reg), .wb_data(wb_data), .exc_pc(exc_pc)
    );

endmodule

// ==== source/alu_pkg.sv ====
package alu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [5:0]  alu_op_t;
    typedef logic [4:0]  exc_code_t;
    typedef logic [4:0]  cp0_addr_t;

    // logic group
    localparam alu_op_t OP_OR   = 6'h00;
    localparam alu_op_t OP_AND  = 6'h01;
    localparam alu_op_t OP_NOR  = 6'h02;
    localparam alu_op_t OP_XOR  = 6'h03;
    localparam alu_op_t OP_LUI  = 6'h04;
    // shifts
    localparam alu_op_t OP_SLL  = 6'h08;
    localparam alu_op_t OP_SRL  = 6'h09;
    localparam alu_op_t OP_SRA  = 6'h0a;
    // add/sub and compares
    localparam alu_op_t OP_ADD  = 6'h10;
    localparam alu_op_t OP_ADDU = 6'h11;
    localparam alu_op_t OP_SUB  = 6'h12;
    localparam alu_op_t OP_SUBU = 6'h13;
    localparam alu_op_t OP_SLT  = 6'h18;
    localparam alu_op_t OP_SLTU = 6'h19;
    // leading count
    localparam alu_op_t OP_CLZ  = 6'h20;
    localparam alu_op_t OP_CLO  = 6'h21;
    // branch resolve
    localparam alu_op_t OP_BEQ  = 6'h28;
    localparam alu_op_t OP_BNE  = 6'h29;
    localparam alu_op_t OP_BGEZ = 6'h2a;
    localparam alu_op_t OP_BLTZ = 6'h2b;
    localparam alu_op_t OP_JR   = 6'h2c;
    localparam alu_op_t OP_JAL  = 6'h2d;
    // coprocessor 0 moves
    localparam alu_op_t OP_MFC0 = 6'h30;
    localparam alu_op_t OP_MTC0 = 6'h31;

    localparam exc_code_t EXC_NONE    = 5'd0;
    localparam exc_code_t EXC_ADEL_IF = 5'd4;
    localparam exc_code_t EXC_OV      = 5'd12;

    localparam cp0_addr_t CP0_BADVADDR = 5'd8;
    localparam cp0_addr_t CP0_CAUSE    = 5'd13;
    localparam cp0_addr_t CP0_EPC      = 5'd14;

endpackage

// ==== source/cp0_regs.sv ====
module cp0_regs (
    input  logic               clk,
    input  logic               arst_n,
    input  alu_pkg::cp0_addr_t addr,
    input  alu_pkg::word_t     wdata,
    input  logic               we,
    output alu_pkg::word_t     rdata,
    input  logic               exc_en,
    input  alu_pkg::word_t     exc_pc,
    input  alu_pkg::word_t     exc_badvaddr,
    input  alu_pkg::exc_code_t exc_code
);
    import alu_pkg::*;

    word_t     epc;
    word_t     badvaddr;
    exc_code_t cause_exc;  // cause bits 6:2

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            epc       <= '0;
            badvaddr  <= '0;
            cause_exc <= EXC_NONE;
        end else if (exc_en) begin
            epc       <= exc_pc;
            cause_exc <= exc_code;
            if (exc_code == EXC_ADEL_IF) badvaddr <= exc_badvaddr;
        end else if (we && (addr == CP0_EPC)) begin
            epc <= wdata;
        end
    end

    always_comb begin
        case (addr)
            CP0_EPC:      rdata = epc;
            CP0_BADVADDR: rdata = badvaddr;
            CP0_CAUSE:    rdata = {25'b0, cause_exc, 2'b00};
            default:      rdata = '0;
        endcase
    end

endmodule

// ==== source/issue_stage.sv ====
module issue_stage #(
    parameter int PREG_BITS = 6,
    parameter int ID_BITS   = 4
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 issue_req,
    output logic                 issue_ack,
    input  alu_pkg::alu_op_t     op,
    input  logic [ID_BITS-1:0]   id,
    input  alu_pkg::word_t       pc,
    input  alu_pkg::word_t       imm,
    input  logic [PREG_BITS-1:0] src0_reg,
    input  logic [PREG_BITS-1:0] src1_reg,
    input  logic                 src1_is_imm,
    input  logic [PREG_BITS-1:0] dst_reg,
    input  logic                 dst_we,
    input  alu_pkg::word_t       pred_target,
    input  alu_pkg::cp0_addr_t   cp0_addr,
    output logic [PREG_BITS-1:0] raddr0,
    output logic [PREG_BITS-1:0] raddr1,
    output logic                 ex_valid,
    output alu_pkg::alu_op_t     ex_op,
    output logic [ID_BITS-1:0]   ex_id,
    output alu_pkg::word_t       ex_pc,
    output alu_pkg::word_t       ex_imm,
    output logic                 ex_src1_is_imm,
    output logic [PREG_BITS-1:0] ex_dst_reg,
    output logic                 ex_dst_we,
    output alu_pkg::word_t       ex_pred_target,
    output alu_pkg::cp0_addr_t   ex_cp0_addr
);
    import alu_pkg::*;

    typedef enum logic {IDLE, HOLD} state_t;

    state_t state;
    logic   capture;

    assign capture   = (state == IDLE) && issue_req;
    assign issue_ack = (state == HOLD);

    // four-phase responder
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= capture;  // one cycle after capture
            case (state)
                IDLE: if (issue_req) state <= HOLD;
                HOLD: if (!issue_req) state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_op          <= OP_OR;
            ex_id          <= '0;
            ex_pc          <= '0;
            ex_imm         <= '0;
            raddr0         <= '0;
            raddr1         <= '0;
            ex_src1_is_imm <= 1'b0;
            ex_dst_reg     <= '0;
            ex_dst_we      <= 1'b0;
            ex_pred_target <= '0;
            ex_cp0_addr    <= '0;
        end else if (capture) begin
            ex_op          <= op;
            ex_id          <= id;
            ex_pc          <= pc;
            ex_imm         <= imm;
            raddr0         <= src0_reg;
            raddr1         <= src1_reg;
            ex_src1_is_imm <= src1_is_imm;
            ex_dst_reg     <= dst_reg;
            ex_dst_we      <= dst_we;
            ex_pred_target <= pred_target;
            ex_cp0_addr    <= cp0_addr;
        end
    end

endmodule

// ==== source/prf.sv ====
module prf #(
    parameter int PREG_BITS = 6
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [PREG_BITS-1:0] raddr0,
    input  logic [PREG_BITS-1:0] raddr1,
    output alu_pkg::word_t       rdata0,
    output alu_pkg::word_t       rdata1,
    input  logic                 we,
    input  logic [PREG_BITS-1:0] waddr,
    input  alu_pkg::word_t       wdata
);
    import alu_pkg::*;

    localparam int NUM_REGS = 2 ** PREG_BITS;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin  // reg 0 stays zero
            regs[waddr] <= wdata;
        end
    end

    // asynchronous reads
    assign rdata0 = regs[raddr0];
    assign rdata1 = regs[raddr1];

endmodule

// ==== source/wb_stage.sv ====
module wb_stage #(
    parameter int PREG_BITS = 6,
    parameter int ID_BITS   = 4
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 res_valid,
    input  logic [ID_BITS-1:0]   res_id,
    input  alu_pkg::word_t       res_data,
    input  logic [PREG_BITS-1:0] res_reg,
    input  logic                 res_we,
    input  logic                 res_exc,
    input  alu_pkg::exc_code_t   res_exc_code,
    input  logic                 res_br,
    input  logic                 res_taken,
    input  alu_pkg::word_t       res_target,
    input  alu_pkg::word_t       res_pc,
    output logic                 done,
    output logic [ID_BITS-1:0]   done_id,
    output logic                 exc,
    output alu_pkg::exc_code_t   exc_code,
    output logic                 br_taken,
    output alu_pkg::word_t       br_target,
    output logic                 wb_we,
    output logic [PREG_BITS-1:0] wb_reg,
    output alu_pkg::word_t       wb_data,
    output alu_pkg::word_t       exc_pc
);
    import alu_pkg::*;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done      <= 1'b0;
            done_id   <= '0;
            exc       <= 1'b0;
            exc_code  <= EXC_NONE;
            br_taken  <= 1'b0;
            br_target <= '0;
            wb_we     <= 1'b0;
            wb_reg    <= '0;
            wb_data   <= '0;
            exc_pc    <= '0;
        end else begin
            done      <= res_valid;
            done_id   <= res_id;
            exc       <= res_exc;
            exc_code  <= res_exc_code;
            br_taken  <= res_taken;
            br_target <= res_br ? res_target : '0;
            wb_we     <= res_we && !res_exc;  // faulting op writes nothing
            wb_reg    <= res_reg;
            wb_data   <= res_data;
            exc_pc    <= res_pc;
        end
    end

endmodule

// ==== src.f ====
source/alu_pkg.sv
source/prf.sv
source/issue_stage.sv
source/alu.sv
source/cp0_regs.sv
source/wb_stage.sv
source/alu_cluster.sv
verification/alu_cluster_sva.sv
verification/alu_cluster_tb.sv

// ==== verification/alu_cluster_sva.sv ====
module alu_cluster_sva (
    input logic clk,
    input logic arst_n,
    input logic issue_req,
    input logic issue_ack,
    input logic done,
    input logic wb_we,
    input logic exc
);

    // ack answers a request seen at the capture edge
    ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(issue_ack) |-> $past(issue_req))
        else $error("issue_ack rose without issue_req");

    done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        done |=> !done)
        else $error("done held longer than one cycle");

    no_write_on_exc: assert property (@(posedge clk) disable iff (!arst_n)
        !(wb_we && exc))
        else $error("register write together with an exception");

    ack_low_in_reset: assert property (@(posedge clk)
        !arst_n |-> !issue_ack)
        else $error("issue_ack high during reset");

endmodule

bind alu_cluster alu_cluster_sva sva0 (
    .clk(clk), .arst_n(arst_n), .issue_req(issue_req), .issue_ack(issue_ack),
    .done(done), .wb_we(wb_we), .exc(exc)
);

// ==== verification/alu_cluster_tb.sv ====
module alu_cluster_tb;
    import alu_pkg::*;

    localparam int PREG_BITS = 6;
    localparam int ID_BITS   = 4;
    localparam int TIMEOUT   = 20;

    typedef struct packed {
        alu_op_t   op;
        logic [3:0] id;
        word_t     pc;
        word_t     imm;
        logic [5:0] s0;
        logic [5:0] s1;
        logic      is_imm;
        logic [5:0] dst;
        logic      dst_we;
        word_t     pred;
        cp0_addr_t ca;
        logic      exp_we;
        word_t     exp_data;
        logic      exp_exc;
        exc_code_t exp_code;
        logic      exp_taken;
        word_t     exp_target;
    } row_t;

    logic                 clk;
    logic                 arst_n;
    logic                 issue_req;
    logic                 issue_ack;
    alu_op_t              op;
    logic [ID_BITS-1:0]   id;
    word_t                pc;
    word_t                imm;
    logic [PREG_BITS-1:0] src0_reg;
    logic [PREG_BITS-1:0] src1_reg;
    logic                 src1_is_imm;
    logic [PREG_BITS-1:0] dst_reg;
    logic                 dst_we;
    word_t                pred_target;
    cp0_addr_t            cp0_addr;
    logic                 done;
    logic [ID_BITS-1:0]   done_id;
    logic                 exc;
    exc_code_t            exc_code;
    logic                 br_taken;
    word_t                br_target;
    logic                 wb_we;
    logic [PREG_BITS-1:0] wb_reg;
    word_t                wb_data;

    row_t      rows[$];
    word_t     mregs[64];  // reference register file
    word_t     m_epc;
    word_t     m_badv;
    exc_code_t m_cause;
    int        errors;
    int        timeouts;
    int        issued;
    int        done_count;

    alu_cluster #(.PREG_BITS(PREG_BITS), .ID_BITS(ID_BITS)) dut0 (
        .clk(clk), .arst_n(arst_n), .issue_req(issue_req), .issue_ack(issue_ack),
        .op(op), .id(id), .pc(pc), .imm(imm), .src0_reg(src0_reg), .src1_reg(src1_reg),
        .src1_is_imm(src1_is_imm), .dst_reg(dst_reg), .dst_we(dst_we),
        .pred_target(pred_target), .cp0_addr(cp0_addr), .done(done), .done_id(done_id),
        .exc(exc), .exc_code(exc_code), .br_taken(br_taken), .br_target(br_target),
        .wb_we(wb_we), .wb_reg(wb_reg), .wb_data(wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(negedge clk) begin
        if (arst_n && done) done_count++;
    end

    // expected values from the op rules, tracked against model state
    function automatic void add_row(input alu_op_t o, input int s0, input int s1,
            input logic is_imm, input word_t im, input int dst, input logic dwe,
            input word_t pred, input cp0_addr_t ca);
        row_t   r;
        word_t  a;
        word_t  b;
        word_t  res;
        word_t  tgt;
        word_t  t;
        longint wide;
        logic   ov;
        logic   taken;
        logic   is_br;
        logic   adel;
        int     n;
        r.pc = 32'h0040_0000 + 32'(rows.size()) * 32'd4;
        r.id = 4'(rows.size());
        a = mregs[s0];
        b = is_imm ? im : mregs[s1];
        res = '0;
        tgt = '0;
        ov = 1'b0;
        taken = 1'b0;
        is_br = 1'b0;
        case (o)
            OP_OR:   res = a | b;
            OP_AND:  res = a & b;
            OP_NOR:  res = ~(a | b);
            OP_XOR:  res = a ^ b;
            OP_LUI:  res = {b[15:0], 16'h0000};
            OP_SLL:  res = a << b[4:0];
            OP_SRL:  res = a >> b[4:0];
            OP_SRA:  res = (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
            OP_ADD, OP_ADDU: begin
                res  = a + b;
                wide = longint'($signed(a)) + longint'($signed(b));
                ov   = (o == OP_ADD) && (wide != longint'($signed(res)));
            end
            OP_SUB, OP_SUBU: begin
                res  = a - b;
                wide = longint'($signed(a)) - longint'($signed(b));
                ov   = (o == OP_SUB) && (wide != longint'($signed(res)));
            end
            OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU: res = (a < b) ? 32'd1 : 32'd0;
            OP_CLZ, OP_CLO: begin
                t = (o == OP_CLO) ? ~a : a;
                n = 0;
                while (n < 32 && !t[31]) begin
                    t = t << 1;
                    n++;
                end
                res = 32'(n);
            end
            OP_BEQ, OP_BNE, OP_BGEZ, OP_BLTZ, OP_JR, OP_JAL: begin
                is_br = 1'b1;
                res   = r.pc + 32'd8;  // link address
                tgt   = (o == OP_JR) ? a : pred;
                case (o)
                    OP_BEQ:  taken = (a == b);
                    OP_BNE:  taken = (a != b);
                    OP_BGEZ: taken = !a[31];
                    OP_BLTZ: taken = a[31];
                    default: taken = 1'b1;
                endcase
            end
            OP_MFC0: begin
                if (ca == CP0_EPC) res = m_epc;
                else if (ca == CP0_BADVADDR) res = m_badv;
                else if (ca == CP0_CAUSE) res = {25'b0, m_cause, 2'b00};
            end
            default: res = '0;
        endcase
        adel = taken && (tgt[1:0] != 2'b00);
        r.op = o;
        r.imm = im;
        r.s0 = 6'(s0);
        r.s1 = 6'(s1);
        r.is_imm = is_imm;
        r.dst = 6'(dst);
        r.dst_we = dwe;
        r.pred = pred;
        r.ca = ca;
        r.exp_exc = adel || ov;
        r.exp_code = adel ? EXC_ADEL_IF : (ov ? EXC_OV : EXC_NONE);
        r.exp_we = dwe && !r.exp_exc;
        r.exp_data = res;
        r.exp_taken = taken;
        r.exp_target = is_br ? tgt : '0;
        if (r.exp_exc) begin
            m_epc   = r.pc;
            m_cause = r.exp_code;
            if (adel) m_badv = tgt;
        end else if (o == OP_MTC0 && ca == CP0_EPC) begin
            m_epc = a;
        end
        if (r.exp_we && dst != 0) mregs[dst] = res;
        rows.push_back(r);
    endfunction

    function automatic void add_reg_op(input alu_op_t o, input int s0, input int s1,
            input int dst);
        add_row(o, s0, s1, 1'b0, '0, dst, 1'b1, '0, '0);
    endfunction

    function automatic void add_imm_op(input alu_op_t o, input int s0, input word_t im,
            input int dst);
        add_row(o, s0, 0, 1'b1, im, dst, 1'b1, '0, '0);
    endfunction

    function automatic void load_word(input int dst, input word_t w);
        add_imm_op(OP_LUI, 0, {16'h0000, w[31:16]}, dst);
        add_imm_op(OP_OR, dst, {16'h0000, w[15:0]}, dst);
    endfunction

    function automatic void add_branch(input alu_op_t o, input int s0, input int s1,
            input word_t pred);
        add_row(o, s0, s1, 1'b0, '0, 0, 1'b0, pred, '0);
    endfunction

    function automatic void add_cp0_read(input cp0_addr_t ca, input int dst);
        add_row(OP_MFC0, 0, 0, 1'b0, '0, dst, 1'b1, '0, ca);
    endfunction

    function automatic void build_table();
        alu_op_t rand_ops [13];
        rand_ops = '{OP_OR, OP_AND, OP_NOR, OP_XOR, OP_SLL, OP_SRL, OP_SRA,
                     OP_ADDU, OP_SUBU, OP_SLT, OP_SLTU, OP_CLZ, OP_CLO};
        add_imm_op(OP_OR, 0, 32'h0000_1234, 1);
        add_imm_op(OP_LUI, 0, 32'h0000_abcd, 2);
        for (int k = 3; k <= 10; k++) load_word(k, $urandom());
        load_word(11, 32'hffff_ffff);
        load_word(12, 32'h7fff_ffff);
        load_word(13, 32'h8000_0000);
        add_imm_op(OP_OR, 0, 32'd31, 14);  // largest shift count
        load_word(15, 32'h0040_0123);       // misaligned jump address
        for (int k = 0; k < 60; k++) begin
            add_reg_op(rand_ops[$urandom_range(12, 0)], $urandom_range(15, 0),
                       $urandom_range(15, 0), $urandom_range(40, 20));
        end
        add_reg_op(OP_SLL, 11, 14, 41);
        add_reg_op(OP_SRA, 13, 14, 42);
        add_reg_op(OP_SRL, 11, 14, 43);
        add_imm_op(OP_SRA, 12, 32'd31, 44);
        add_reg_op(OP_CLZ, 0, 0, 45);   // zero counts 32
        add_reg_op(OP_CLO, 11, 0, 46);
        add_reg_op(OP_CLZ, 13, 0, 47);
        add_reg_op(OP_SLT, 13, 12, 48);
        add_reg_op(OP_SLTU, 13, 12, 49);
        add_reg_op(OP_NOR, 0, 0, 50);
        // signed overflow
        add_reg_op(OP_ADD, 12, 1, 30);
        add_cp0_read(CP0_EPC, 31);
        add_reg_op(OP_SUB, 13, 1, 30);
        add_cp0_read(CP0_CAUSE, 31);
        add_reg_op(OP_ADD, 3, 1, 30);
        add_branch(OP_BEQ, 3, 3, 32'h0040_0800);
        add_branch(OP_BEQ, 11, 0, 32'h0040_0810);
        add_branch(OP_BNE, 11, 0, 32'h0040_0820);
        add_branch(OP_BNE, 4, 4, 32'h0040_0830);
        add_branch(OP_BGEZ, 13, 0, 32'h0040_0840);
        add_branch(OP_BLTZ, 13, 0, 32'h0040_0850);
        add_row(OP_JAL, 0, 0, 1'b0, '0, 31, 1'b1, 32'h0040_0a00, '0);
        add_row(OP_JR, 15, 0, 1'b0, '0, 0, 1'b0, '0, '0);
        add_cp0_read(CP0_BADVADDR, 32);
        add_cp0_read(CP0_EPC, 33);
        add_row(OP_MTC0, 5, 0, 1'b0, '0, 0, 1'b0, '0, CP0_EPC);
        add_cp0_read(CP0_EPC, 34);
        add_reg_op(OP_OR, 34, 0, 35);  // result read back through the prf
    endfunction

    task automatic report_mismatch(input int idx, input string what, input word_t got,
            input word_t exp);
        $display("FAILED at %0t: row %0d op %h %s got %h expected %h",
                 $time, idx, rows[idx].op, what, got, exp);
        errors++;
    endtask

    task automatic apply_row(input int idx, output logic hung);
        row_t r;
        int   n;
        r = rows[idx];
        hung = 1'b0;
        n = 0;
        while (issue_ack && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (issue_ack) begin
            $display("timeout: issue_ack never dropped before row %0d", idx);
            hung = 1'b1;
            return;
        end
        op = r.op;
        id = r.id;
        pc = r.pc;
        imm = r.imm;
        src0_reg = r.s0;
        src1_reg = r.s1;
        src1_is_imm = r.is_imm;
        dst_reg = r.dst;
        dst_we = r.dst_we;
        pred_target = r.pred;
        cp0_addr = r.ca;
        issue_req = 1'b1;
        issued++;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!issue_ack && n < TIMEOUT);
        if (!issue_ack) begin
            $display("timeout: issue_ack never rose for row %0d", idx);
            hung = 1'b1;
            return;
        end
        issue_req = 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!done && n < TIMEOUT);
        if (!done) begin
            $display("timeout: done never came for row %0d", idx);
            hung = 1'b1;
            return;
        end
        if (n != 1) begin
            $display("FAILED at %0t: row %0d done came %0d cycles after issue_ack",
                     $time, idx, n);
            errors++;
        end
        if (done_id !== r.id) begin
            report_mismatch(idx, "done_id", 32'(done_id), 32'(r.id));
        end
        if (wb_we !== r.exp_we) begin
            report_mismatch(idx, "wb_we", 32'(wb_we), 32'(r.exp_we));
        end
        if (r.exp_we && wb_reg !== r.dst) begin
            report_mismatch(idx, "wb_reg", 32'(wb_reg), 32'(r.dst));
        end
        if (r.exp_we && wb_data !== r.exp_data) begin
            report_mismatch(idx, "wb_data", wb_data, r.exp_data);
        end
        if (exc !== r.exp_exc) begin
            report_mismatch(idx, "exc", 32'(exc), 32'(r.exp_exc));
        end
        if (exc_code !== r.exp_code) begin
            report_mismatch(idx, "exc_code", 32'(exc_code), 32'(r.exp_code));
        end
        if (br_taken !== r.exp_taken) begin
            report_mismatch(idx, "br_taken", 32'(br_taken), 32'(r.exp_taken));
        end
        if (br_target !== r.exp_target) begin
            report_mismatch(idx, "br_target", br_target, r.exp_target);
        end
    endtask

    initial begin
        logic hung;
        void'($urandom(32'hce1d_d13f));
        errors = 0;
        timeouts = 0;
        issued = 0;
        done_count = 0;
        hung = 1'b0;
        arst_n = 1'b0;
        issue_req = 1'b0;
        op = OP_OR;
        id = '0;
        pc = '0;
        imm = '0;
        src0_reg = '0;
        src1_reg = '0;
        src1_is_imm = 1'b0;
        dst_reg = '0;
        dst_we = 1'b0;
        pred_target = '0;
        cp0_addr = '0;
        for (int i = 0; i < 64; i++) mregs[i] = '0;
        m_epc = '0;
        m_badv = '0;
        m_cause = EXC_NONE;
        build_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < rows.size() && !hung; i++) begin
            apply_row(i, hung);
        end
        if (hung) timeouts++;
        repeat (3) @(negedge clk);
        if (!hung && done_count != issued) begin
            $display("FAILED at %0t: %0d done pulses for %0d issued ops",
                     $time, done_count, issued);
            errors++;
        end
        $display("errors: %0d mismatches, %0d timeouts, %0d of %0d rows issued",
                 errors, timeouts, issued, rows.size());
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
